//--- common/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// datapath widths
`define CSR_XLEN       64
`define CSR_ADDR_W     12
`define CSR_PAYLOAD_W  134

// queue depth, equal to the credits the sender starts with
`define CSR_CREDITS    4

// machine csr addresses
`define CSR_MSTATUS    12'h300
`define CSR_MIE        12'h304
`define CSR_MTVEC      12'h305
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342
`define CSR_MTVAL      12'h343
`define CSR_MIP        12'h344
// custom slot for the timer compare register
`define CSR_MTIMECMP   12'h7C0
// user time, read-only
`define CSR_TIME       12'hC01

// mpp held at machine mode
`define CSR_MSTATUS_RESET 64'h0000_0000_0000_1800

// mstatus fields
`define CSR_MIE_BIT    3
`define CSR_MPIE_BIT   7
`define CSR_MPP_HI     12
`define CSR_MPP_LO     11

// timer interrupt bit in mip and mie
`define CSR_MTIP_BIT   7
`define CSR_MTIE_BIT   7

`endif

//--- common/csr_pkg.sv
`include "csr_consts.svh"

package csr_pkg;

  // what the core asks for in one command
  typedef enum logic [1:0] {
    ACCESS = 2'd0,
    TRAP   = 2'd1,
    MRET   = 2'd2,
    NOP    = 2'd3
  } csr_cmd_kind_e;

  // csrrw / csrrs / csrrc
  typedef enum logic [1:0] {
    RW = 2'd0,
    RS = 2'd1,
    RC = 2'd2
  } csr_op_e;

  // payload as seen by an access command
  typedef struct packed {
    logic [`CSR_ADDR_W-1:0]                           addr;
    csr_op_e                                          op;
    logic [`CSR_XLEN-1:0]                             wdata;
    logic [`CSR_PAYLOAD_W-`CSR_ADDR_W-2-`CSR_XLEN-1:0] pad;
  } csr_access_t;

  // payload as seen by a trap command
  typedef struct packed {
    logic [`CSR_XLEN-1:0] pc;
    logic [`CSR_XLEN-1:0] tval;
    logic                 interrupt;
    logic [4:0]           code;
  } csr_trap_t;

  // one word, decoded by command kind
  typedef union packed {
    csr_access_t acc;
    csr_trap_t   trp;
  } csr_payload_u;

endpackage

//--- csr_regfile/csr_regfile.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_regfile (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [`CSR_ADDR_W-1:0] rd_addr_i,
  input  logic                   wr_en_i,
  input  logic [`CSR_ADDR_W-1:0] wr_addr_i,
  input  logic [`CSR_XLEN-1:0]   wr_data_i,
  input  logic                   trap_en_i,
  input  logic [`CSR_XLEN-1:0]   trap_pc_i,
  input  logic [5:0]             trap_cause_i,
  input  logic [`CSR_XLEN-1:0]   trap_tval_i,
  input  logic                   mret_en_i,
  input  logic [`CSR_XLEN-1:0]   mtime_i,
  input  logic [`CSR_XLEN-1:0]   mtimecmp_i,
  input  logic                   mtip_i,
  output logic [`CSR_XLEN-1:0]   rd_data_o,
  output logic                   addr_legal_o,
  output logic                   addr_ro_o,
  output logic [`CSR_XLEN-1:0]   mstatus_o,
  output logic [`CSR_XLEN-1:0]   mie_o,
  output logic [`CSR_XLEN-1:0]   mip_o,
  output logic [`CSR_XLEN-1:0]   mepc_o,
  output logic [`CSR_XLEN-1:0]   mtvec_o,
  output logic                   mtimecmp_we_o,
  output logic [`CSR_XLEN-1:0]   mtimecmp_wdata_o
);

  logic [`CSR_XLEN-1:0] mstatus_q;
  logic [`CSR_XLEN-1:0] mepc_q;
  logic [`CSR_XLEN-1:0] mcause_q;
  logic [`CSR_XLEN-1:0] mtval_q;
  logic [`CSR_XLEN-1:0] mtvec_q;
  logic [`CSR_XLEN-1:0] mie_q;
  logic [`CSR_XLEN-1:0] mip_q;
  logic                 mstatus_we;
  logic                 mepc_we;
  logic                 mcause_we;
  logic                 mtval_we;
  logic                 mtvec_we;
  logic                 mie_we;
  logic                 mip_we;
  logic [`CSR_XLEN-1:0] mstatus_wdata;
  logic [`CSR_XLEN-1:0] mip_wdata;
  logic [`CSR_XLEN-1:0] mip_rd;

  // software write enables from the write address
  always_comb begin
    mstatus_we    = 1'b0;
    mepc_we       = 1'b0;
    mcause_we     = 1'b0;
    mtval_we      = 1'b0;
    mtvec_we      = 1'b0;
    mie_we        = 1'b0;
    mip_we        = 1'b0;
    mtimecmp_we_o = 1'b0;
    if (wr_en_i) begin
      case (wr_addr_i)
        `CSR_MSTATUS:  mstatus_we = 1'b1;
        `CSR_MEPC:     mepc_we = 1'b1;
        `CSR_MCAUSE:   mcause_we = 1'b1;
        `CSR_MTVAL:    mtval_we = 1'b1;
        `CSR_MTVEC:    mtvec_we = 1'b1;
        `CSR_MIE:      mie_we = 1'b1;
        `CSR_MIP:      mip_we = 1'b1;
        `CSR_MTIMECMP: mtimecmp_we_o = 1'b1;
        default: ;
      endcase
    end
  end

  assign mtimecmp_wdata_o = wr_data_i;

  // mpp is pinned to machine mode, mtip belongs to the timer
  always_comb begin
    mstatus_wdata = wr_data_i;
    mstatus_wdata[`CSR_MPP_HI:`CSR_MPP_LO] = 2'b11;
    mip_wdata = wr_data_i;
    mip_wdata[`CSR_MTIP_BIT] = 1'b0;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mstatus_q <= `CSR_MSTATUS_RESET;
    end else if (trap_en_i) begin
      mstatus_q[`CSR_MPIE_BIT] <= mstatus_q[`CSR_MIE_BIT];
      mstatus_q[`CSR_MIE_BIT]  <= 1'b0;
    end else if (mret_en_i) begin
      mstatus_q[`CSR_MIE_BIT]  <= mstatus_q[`CSR_MPIE_BIT];
      mstatus_q[`CSR_MPIE_BIT] <= 1'b1;
    end else if (mstatus_we) begin
      mstatus_q <= mstatus_wdata;
    end
  end

  // trap port wins over software writes
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mepc_q   <= '0;
      mcause_q <= '0;
      mtval_q  <= '0;
    end else if (trap_en_i) begin
      mepc_q   <= {trap_pc_i[`CSR_XLEN-1:1], 1'b0};
      mcause_q <= {trap_cause_i[5], {(`CSR_XLEN-6){1'b0}}, trap_cause_i[4:0]};
      mtval_q  <= trap_tval_i;
    end else begin
      if (mepc_we) begin
        mepc_q <= wr_data_i;
      end
      if (mcause_we) begin
        mcause_q <= wr_data_i;
      end
      if (mtval_we) begin
        mtval_q <= wr_data_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtvec_q <= '0;
      mie_q   <= '0;
      mip_q   <= '0;
    end else begin
      if (mtvec_we) begin
        mtvec_q <= wr_data_i;
      end
      if (mie_we) begin
        mie_q <= wr_data_i;
      end
      if (mip_we) begin
        mip_q <= mip_wdata;
      end
    end
  end

  always_comb begin
    mip_rd = mip_q;
    mip_rd[`CSR_MTIP_BIT] = mtip_i;
  end

  always_comb begin
    rd_data_o    = '0;
    addr_legal_o = 1'b1;
    case (rd_addr_i)
      `CSR_MSTATUS:  rd_data_o = mstatus_q;
      `CSR_MEPC:     rd_data_o = mepc_q;
      `CSR_MCAUSE:   rd_data_o = mcause_q;
      `CSR_MTVAL:    rd_data_o = mtval_q;
      `CSR_MTVEC:    rd_data_o = mtvec_q;
      `CSR_MIE:      rd_data_o = mie_q;
      `CSR_MIP:      rd_data_o = mip_rd;
      `CSR_MTIMECMP: rd_data_o = mtimecmp_i;
      `CSR_TIME:     rd_data_o = mtime_i;
      default:       addr_legal_o = 1'b0;
    endcase
  end

  // address bits 11:10 both set means a read-only csr
  assign addr_ro_o = &rd_addr_i[`CSR_ADDR_W-1:`CSR_ADDR_W-2];

  assign mstatus_o = mstatus_q;
  assign mie_o     = mie_q;
  assign mip_o     = mip_rd;
  assign mepc_o    = mepc_q;
  assign mtvec_o   = mtvec_q;

endmodule

//--- logic/mtimer.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module mtimer (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 cmp_we_i,
  input  logic [`CSR_XLEN-1:0] cmp_wdata_i,
  output logic [`CSR_XLEN-1:0] mtime_o,
  output logic [`CSR_XLEN-1:0] mtimecmp_o,
  output logic                 mtip_o
);

  logic [`CSR_XLEN-1:0] mtime_q;
  logic [`CSR_XLEN-1:0] mtimecmp_q;

  // free running, one tick per clock
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  // all ones keeps mtip low out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtimecmp_q <= {`CSR_XLEN{1'b1}};
    end else if (cmp_we_i) begin
      mtimecmp_q <= cmp_wdata_i;
    end
  end

  // level, not a pulse
  assign mtip_o = (mtime_q >= mtimecmp_q);

  assign mtime_o    = mtime_q;
  assign mtimecmp_o = mtimecmp_q;

endmodule

//--- logic/csr_cmd_fifo.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_cmd_fifo (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   push_i,
  input  csr_pkg::csr_cmd_kind_e kind_i,
  input  csr_pkg::csr_payload_u  payload_i,
  input  logic                   pop_i,
  output csr_pkg::csr_cmd_kind_e kind_o,
  output csr_pkg::csr_payload_u  payload_o,
  output logic                   not_empty_o,
  output logic                   credit_o
);

  localparam int DEPTH = `CSR_CREDITS;
  localparam int PTR_W = $clog2(DEPTH);

  csr_pkg::csr_cmd_kind_e kind_mem [DEPTH];
  csr_pkg::csr_payload_u  payload_mem [DEPTH];
  logic [PTR_W-1:0]       wr_ptr_q;
  logic [PTR_W-1:0]       rd_ptr_q;
  logic [PTR_W:0]         count_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      kind_mem[wr_ptr_q]    <= kind_i;
      payload_mem[wr_ptr_q] <= payload_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + {{PTR_W{1'b0}}, push_i} - {{PTR_W{1'b0}}, pop_i};
      // credit goes back once the entry has left
      credit_o <= pop_i;
    end
  end

  assign kind_o      = kind_mem[rd_ptr_q];
  assign payload_o   = payload_mem[rd_ptr_q];
  assign not_empty_o = (count_q != '0);

  // sender must hold a credit for every push
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> (count_q != (PTR_W + 1)'(DEPTH)));
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> not_empty_o);

endmodule

//--- logic/csr_exec.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_exec (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   not_empty_i,
  input  csr_pkg::csr_cmd_kind_e kind_i,
  input  csr_pkg::csr_payload_u  payload_i,
  output logic                   pop_o,
  output logic [`CSR_ADDR_W-1:0] rd_addr_o,
  output logic                   wr_en_o,
  output logic [`CSR_ADDR_W-1:0] wr_addr_o,
  output logic [`CSR_XLEN-1:0]   wr_data_o,
  output logic                   trap_en_o,
  output logic [`CSR_XLEN-1:0]   trap_pc_o,
  output logic [5:0]             trap_cause_o,
  output logic [`CSR_XLEN-1:0]   trap_tval_o,
  output logic                   mret_en_o,
  input  logic [`CSR_XLEN-1:0]   rd_data_i,
  input  logic                   addr_legal_i,
  input  logic                   addr_ro_i,
  input  logic [`CSR_XLEN-1:0]   mstatus_i,
  input  logic [`CSR_XLEN-1:0]   mie_i,
  input  logic [`CSR_XLEN-1:0]   mip_i,
  input  logic [`CSR_XLEN-1:0]   mepc_i,
  input  logic [`CSR_XLEN-1:0]   mtvec_i,
  output logic                   rsp_valid_o,
  output logic [`CSR_XLEN-1:0]   rsp_rdata_o,
  output logic                   rsp_error_o,
  output logic                   rsp_redirect_o,
  output logic [`CSR_XLEN-1:0]   rsp_target_o,
  output logic                   irq_pending_o
);

  csr_pkg::csr_access_t acc;
  csr_pkg::csr_trap_t   trp;
  logic                 acc_err;
  logic [`CSR_XLEN-1:0] new_val;
  logic [`CSR_XLEN-1:0] rdata_d;
  logic                 error_d;
  logic                 redirect_d;
  logic [`CSR_XLEN-1:0] target_d;

  assign acc   = payload_i.acc;
  assign trp   = payload_i.trp;
  assign pop_o = not_empty_i;

  always_comb begin
    case (acc.op)
      csr_pkg::RW: new_val = acc.wdata;
      csr_pkg::RS: new_val = rd_data_i | acc.wdata;
      csr_pkg::RC: new_val = rd_data_i & ~acc.wdata;
      default:     new_val = rd_data_i;
    endcase
  end

  assign acc_err   = !addr_legal_i || (addr_ro_i && (acc.wdata != '0));
  assign rd_addr_o = acc.addr;
  assign wr_addr_o = acc.addr;
  assign wr_data_o = new_val;
  // no write into unknown or read-only csrs
  assign wr_en_o = not_empty_i && (kind_i == csr_pkg::ACCESS) && addr_legal_i && !addr_ro_i;

  assign trap_en_o    = not_empty_i && (kind_i == csr_pkg::TRAP);
  assign trap_pc_o    = trp.pc;
  assign trap_cause_o = {trp.interrupt, trp.code};
  assign trap_tval_o  = trp.tval;
  assign mret_en_o    = not_empty_i && (kind_i == csr_pkg::MRET);

  always_comb begin
    rdata_d    = '0;
    error_d    = 1'b0;
    redirect_d = 1'b0;
    target_d   = '0;
    case (kind_i)
      csr_pkg::ACCESS: begin
        rdata_d = rd_data_i;
        error_d = acc_err;
      end
      csr_pkg::TRAP: begin
        // direct mode only
        redirect_d = 1'b1;
        target_d   = {mtvec_i[`CSR_XLEN-1:2], 2'b00};
      end
      csr_pkg::MRET: begin
        redirect_d = 1'b1;
        target_d   = mepc_i;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o    <= 1'b0;
      rsp_redirect_o <= 1'b0;
    end else begin
      rsp_valid_o    <= not_empty_i;
      rsp_redirect_o <= not_empty_i && redirect_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (not_empty_i) begin
      rsp_rdata_o  <= rdata_d;
      rsp_error_o  <= error_d;
      rsp_target_o <= target_d;
    end
  end

  assign irq_pending_o = mstatus_i[`CSR_MIE_BIT] & mie_i[`CSR_MTIE_BIT] & mip_i[`CSR_MTIP_BIT];

  // one hardware write source per command
  a_write_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({wr_en_o, trap_en_o, mret_en_o}));

endmodule

//--- logic/csr_top.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   cmd_valid_i,
  input  csr_pkg::csr_cmd_kind_e cmd_kind_i,
  input  csr_pkg::csr_payload_u  cmd_payload_i,
  output logic                   credit_o,
  output logic                   rsp_valid_o,
  output logic [`CSR_XLEN-1:0]   rsp_rdata_o,
  output logic                   rsp_error_o,
  output logic                   rsp_redirect_o,
  output logic [`CSR_XLEN-1:0]   rsp_target_o,
  output logic                   irq_pending_o
);

  csr_pkg::csr_cmd_kind_e head_kind;
  csr_pkg::csr_payload_u  head_payload;
  logic                   head_valid;
  logic                   pop;
  logic [`CSR_ADDR_W-1:0] rd_addr;
  logic                   wr_en;
  logic [`CSR_ADDR_W-1:0] wr_addr;
  logic [`CSR_XLEN-1:0]   wr_data;
  logic                   trap_en;
  logic [`CSR_XLEN-1:0]   trap_pc;
  logic [5:0]             trap_cause;
  logic [`CSR_XLEN-1:0]   trap_tval;
  logic                   mret_en;
  logic [`CSR_XLEN-1:0]   rd_data;
  logic                   addr_legal;
  logic                   addr_ro;
  logic [`CSR_XLEN-1:0]   mstatus;
  logic [`CSR_XLEN-1:0]   mie;
  logic [`CSR_XLEN-1:0]   mip;
  logic [`CSR_XLEN-1:0]   mepc;
  logic [`CSR_XLEN-1:0]   mtvec;
  logic                   cmp_we;
  logic [`CSR_XLEN-1:0]   cmp_wdata;
  logic [`CSR_XLEN-1:0]   mtime;
  logic [`CSR_XLEN-1:0]   mtimecmp;
  logic                   mtip;

  csr_cmd_fifo u_cmd_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (cmd_valid_i),
    .kind_i      (cmd_kind_i),
    .payload_i   (cmd_payload_i),
    .pop_i       (pop),
    .kind_o      (head_kind),
    .payload_o   (head_payload),
    .not_empty_o (head_valid),
    .credit_o    (credit_o)
  );

  csr_exec u_exec (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .not_empty_i    (head_valid),
    .kind_i         (head_kind),
    .payload_i      (head_payload),
    .pop_o          (pop),
    .rd_addr_o      (rd_addr),
    .wr_en_o        (wr_en),
    .wr_addr_o      (wr_addr),
    .wr_data_o      (wr_data),
    .trap_en_o      (trap_en),
    .trap_pc_o      (trap_pc),
    .trap_cause_o   (trap_cause),
    .trap_tval_o    (trap_tval),
    .mret_en_o      (mret_en),
    .rd_data_i      (rd_data),
    .addr_legal_i   (addr_legal),
    .addr_ro_i      (addr_ro),
    .mstatus_i      (mstatus),
    .mie_i          (mie),
    .mip_i          (mip),
    .mepc_i         (mepc),
    .mtvec_i        (mtvec),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_rdata_o    (rsp_rdata_o),
    .rsp_error_o    (rsp_error_o),
    .rsp_redirect_o (rsp_redirect_o),
    .rsp_target_o   (rsp_target_o),
    .irq_pending_o  (irq_pending_o)
  );

  csr_regfile u_regfile (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .rd_addr_i        (rd_addr),
    .wr_en_i          (wr_en),
    .wr_addr_i        (wr_addr),
    .wr_data_i        (wr_data),
    .trap_en_i        (trap_en),
    .trap_pc_i        (trap_pc),
    .trap_cause_i     (trap_cause),
    .trap_tval_i      (trap_tval),
    .mret_en_i        (mret_en),
    .mtime_i          (mtime),
    .mtimecmp_i       (mtimecmp),
    .mtip_i           (mtip),
    .rd_data_o        (rd_data),
    .addr_legal_o     (addr_legal),
    .addr_ro_o        (addr_ro),
    .mstatus_o        (mstatus),
    .mie_o            (mie),
    .mip_o            (mip),
    .mepc_o           (mepc),
    .mtvec_o          (mtvec),
    .mtimecmp_we_o    (cmp_we),
    .mtimecmp_wdata_o (cmp_wdata)
  );

  mtimer u_mtimer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmp_we_i    (cmp_we),
    .cmp_wdata_i (cmp_wdata),
    .mtime_o     (mtime),
    .mtimecmp_o  (mtimecmp),
    .mtip_o      (mtip)
  );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o
);

  localparam real HALF_PERIOD = 4.0;

  initial begin
    clk_o = 1'b0;
  end

  // 8 ns period
  always begin
    #(HALF_PERIOD);
    clk_o = ~clk_o;
  end

endmodule

//--- tests/csr_tb.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_tb;

  localparam int MAX_CYCLES = 2000;
  localparam logic [`CSR_XLEN-1:0] ALL_ONES = {`CSR_XLEN{1'b1}};

  typedef struct packed {
    logic [`CSR_XLEN-1:0] rdata;
    logic [`CSR_XLEN-1:0] mask;
    logic                 error;
    logic                 redirect;
    logic [`CSR_XLEN-1:0] target;
    logic                 is_time;
  } exp_rsp_t;

  logic                   clk;
  logic                   rst_n;
  logic                   cmd_valid;
  csr_pkg::csr_cmd_kind_e cmd_kind;
  csr_pkg::csr_payload_u  cmd_payload;
  logic                   credit;
  logic                   rsp_valid;
  logic [`CSR_XLEN-1:0]   rsp_rdata;
  logic                   rsp_error;
  logic                   rsp_redirect;
  logic [`CSR_XLEN-1:0]   rsp_target;
  logic                   irq_pending;

  // shadow copy of the machine csrs
  logic [`CSR_XLEN-1:0] m_mstatus;
  logic [`CSR_XLEN-1:0] m_mepc;
  logic [`CSR_XLEN-1:0] m_mcause;
  logic [`CSR_XLEN-1:0] m_mtval;
  logic [`CSR_XLEN-1:0] m_mtvec;
  logic [`CSR_XLEN-1:0] m_mie;
  logic [`CSR_XLEN-1:0] m_mip;
  logic [`CSR_XLEN-1:0] m_mtimecmp;

  exp_rsp_t             exp_q [$];
  exp_rsp_t             exp_cur;
  logic                 exp_none;
  logic [`CSR_XLEN-1:0] last_time;
  logic [`CSR_XLEN-1:0] time_floor;
  logic [63:0]          rng;
  int                   sent = 0;
  int                   popped = 0;
  int                   returned = 0;
  int                   cycles = 0;
  int                   since_rst = 0;

  tb_clock u_clock (
    .clk_o (clk)
  );

  csr_top uut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .cmd_valid_i    (cmd_valid),
    .cmd_kind_i     (cmd_kind),
    .cmd_payload_i  (cmd_payload),
    .credit_o       (credit),
    .rsp_valid_o    (rsp_valid),
    .rsp_rdata_o    (rsp_rdata),
    .rsp_error_o    (rsp_error),
    .rsp_redirect_o (rsp_redirect),
    .rsp_target_o   (rsp_target),
    .irq_pending_o  (irq_pending)
  );

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  function automatic logic [63:0] xorshift(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  task automatic draw_rand(output logic [63:0] v);
    rng = xorshift(rng);
    v = rng;
  endtask

  // mtime at execution is never below since_rst at send time
  function automatic logic mtip_known();
    return (m_mtimecmp == ALL_ONES) ||
           ((since_rst > 8) && (m_mtimecmp < 64'(since_rst - 8)));
  endfunction

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (rst_n) begin
      since_rst = since_rst + 1;
    end
    if (cycles > MAX_CYCLES) begin
      $display("timeout: run exceeded %0d cycles, %0d responses missing", MAX_CYCLES,
               sent - popped);
      abort_run();
    end
  end

  // credits back and the response on the bus this cycle
  always @(negedge clk) begin
    if (credit === 1'b1) begin
      returned = returned + 1;
    end
    if (rsp_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        exp_none = 1'b1;
      end else begin
        exp_cur    = exp_q.pop_front();
        exp_none   = 1'b0;
        popped     = popped + 1;
        time_floor = last_time;
        if (exp_cur.is_time) begin
          last_time = rsp_rdata;
        end
      end
    end
  end

  a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> !exp_none)
    else begin
      $display("response arrived with no command outstanding");
      abort_run();
    end

  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !exp_cur.is_time |-> ((rsp_rdata ^ exp_cur.rdata) & exp_cur.mask) == '0)
    else begin
      $display("Mismatch rsp_rdata_o: got %h expected %h mask %h",
               $sampled(rsp_rdata), exp_cur.rdata, exp_cur.mask);
      abort_run();
    end

  a_time: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && exp_cur.is_time |-> (rsp_rdata != '0) && (rsp_rdata > time_floor))
    else begin
      $display("Mismatch rsp_rdata_o: time %h not above previous %h",
               $sampled(rsp_rdata), time_floor);
      abort_run();
    end

  a_error: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> rsp_error == exp_cur.error)
    else begin
      $display("Mismatch rsp_error_o: got %h expected %h", $sampled(rsp_error), exp_cur.error);
      abort_run();
    end

  a_redirect: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> rsp_redirect == exp_cur.redirect)
    else begin
      $display("Mismatch rsp_redirect_o: got %h expected %h",
               $sampled(rsp_redirect), exp_cur.redirect);
      abort_run();
    end

  a_target: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> rsp_target == exp_cur.target)
    else begin
      $display("Mismatch rsp_target_o: got %h expected %h", $sampled(rsp_target), exp_cur.target);
      abort_run();
    end

  a_credits: assert property (@(posedge clk) disable iff (!rst_n)
    (sent - returned >= 0) && (sent - returned <= `CSR_CREDITS))
    else begin
      $display("sender credit count out of range, %0d sent and %0d returned", sent, returned);
      abort_run();
    end

  // sent includes the command being accepted at this edge
  a_idle_latency: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid && (sent - popped == 1) |=> !rsp_valid ##1 rsp_valid)
    else begin
      $display("idle-queue command did not respond exactly 2 cycles after it was sent");
      abort_run();
    end

  task automatic send_cmd(input csr_pkg::csr_cmd_kind_e kind,
                          input csr_pkg::csr_payload_u payload, input exp_rsp_t exp);
    while (sent - returned >= `CSR_CREDITS) begin
      @(negedge clk);
    end
    cmd_valid   = 1'b1;
    cmd_kind    = kind;
    cmd_payload = payload;
    exp_q.push_back(exp);
    sent = sent + 1;
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic csr_access(input logic [`CSR_ADDR_W-1:0] addr, input csr_pkg::csr_op_e op,
                            input logic [`CSR_XLEN-1:0] wdata);
    csr_pkg::csr_payload_u p;
    exp_rsp_t              exp;
    logic [`CSR_XLEN-1:0]  old_val;
    logic [`CSR_XLEN-1:0]  new_val;
    logic                  legal;
    logic                  ro;
    p          = '0;
    p.acc.addr = addr;
    p.acc.op   = op;
    p.acc.wdata = wdata;
    exp        = '0;
    exp.mask   = ALL_ONES;
    legal      = 1'b1;
    old_val    = '0;
    case (addr)
      `CSR_MSTATUS:  old_val = m_mstatus;
      `CSR_MIE:      old_val = m_mie;
      `CSR_MTVEC:    old_val = m_mtvec;
      `CSR_MEPC:     old_val = m_mepc;
      `CSR_MCAUSE:   old_val = m_mcause;
      `CSR_MTVAL:    old_val = m_mtval;
      `CSR_MTIMECMP: old_val = m_mtimecmp;
      `CSR_TIME:     exp.is_time = 1'b1;
      `CSR_MIP: begin
        old_val = m_mip;
        old_val[`CSR_MTIP_BIT] = (m_mtimecmp != ALL_ONES);
        if (!mtip_known()) begin
          exp.mask[`CSR_MTIP_BIT] = 1'b0;
        end
      end
      default:       legal = 1'b0;
    endcase
    // time is the only read-only csr
    ro = (addr == `CSR_TIME);
    case (op)
      csr_pkg::RW: new_val = wdata;
      csr_pkg::RS: new_val = old_val | wdata;
      default:     new_val = old_val & ~wdata;
    endcase
    exp.rdata = old_val;
    exp.error = !legal || (ro && (wdata != '0));
    if (legal && !ro) begin
      case (addr)
        `CSR_MSTATUS: begin
          m_mstatus = new_val;
          m_mstatus[`CSR_MPP_HI:`CSR_MPP_LO] = 2'b11;
        end
        `CSR_MIP: begin
          m_mip = new_val;
          m_mip[`CSR_MTIP_BIT] = 1'b0;
        end
        `CSR_MIE:      m_mie = new_val;
        `CSR_MTVEC:    m_mtvec = new_val;
        `CSR_MEPC:     m_mepc = new_val;
        `CSR_MCAUSE:   m_mcause = new_val;
        `CSR_MTVAL:    m_mtval = new_val;
        `CSR_MTIMECMP: m_mtimecmp = new_val;
        default: ;
      endcase
    end
    send_cmd(csr_pkg::ACCESS, p, exp);
  endtask

  task automatic trap_cmd(input logic [63:0] pc, input logic [63:0] tval, input logic intr,
                          input logic [4:0] code);
    csr_pkg::csr_payload_u p;
    exp_rsp_t              exp;
    p               = '0;
    p.trp.pc        = pc;
    p.trp.tval      = tval;
    p.trp.interrupt = intr;
    p.trp.code      = code;
    exp             = '0;
    exp.mask        = ALL_ONES;
    exp.redirect    = 1'b1;
    exp.target      = m_mtvec & ~64'h3;
    m_mepc          = pc & ~64'h1;
    m_mcause        = {intr, 58'd0, code};
    m_mtval         = tval;
    m_mstatus[`CSR_MPIE_BIT] = m_mstatus[`CSR_MIE_BIT];
    m_mstatus[`CSR_MIE_BIT]  = 1'b0;
    send_cmd(csr_pkg::TRAP, p, exp);
  endtask

  task automatic mret_cmd();
    exp_rsp_t exp;
    exp          = '0;
    exp.mask     = ALL_ONES;
    exp.redirect = 1'b1;
    exp.target   = m_mepc;
    m_mstatus[`CSR_MIE_BIT]  = m_mstatus[`CSR_MPIE_BIT];
    m_mstatus[`CSR_MPIE_BIT] = 1'b1;
    send_cmd(csr_pkg::MRET, '0, exp);
  endtask

  task automatic nop_cmd();
    exp_rsp_t exp;
    exp      = '0;
    exp.mask = ALL_ONES;
    send_cmd(csr_pkg::NOP, '0, exp);
  endtask

  task automatic drain();
    while (popped != sent) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while (irq_pending !== level) begin
      if (n == 100) begin
        $display("irq_pending_o did not reach %0b within 100 cycles", level);
        abort_run();
      end else begin
        n = n + 1;
        @(negedge clk);
      end
    end
  endtask

  function automatic logic [`CSR_ADDR_W-1:0] pick_addr(input logic [2:0] i);
    case (i)
      3'd0:    return `CSR_MSTATUS;
      3'd1:    return `CSR_MIE;
      3'd2:    return `CSR_MTVEC;
      3'd3:    return `CSR_MEPC;
      3'd4:    return `CSR_MCAUSE;
      3'd5:    return `CSR_MTVAL;
      3'd6:    return `CSR_MIP;
      default: return `CSR_MTIMECMP;
    endcase
  endfunction

  initial begin
    logic [63:0]            r;
    logic [63:0]            d;
    logic [`CSR_ADDR_W-1:0] a;
    csr_pkg::csr_op_e       op;
    cmd_valid   = 1'b0;
    cmd_kind    = csr_pkg::NOP;
    cmd_payload = '0;
    rst_n       = 1'b0;
    rng         = 64'd86;
    exp_cur     = '0;
    exp_none    = 1'b0;
    last_time   = '0;
    time_floor  = '0;
    m_mstatus   = `CSR_MSTATUS_RESET;
    m_mepc      = '0;
    m_mcause    = '0;
    m_mtval     = '0;
    m_mtvec     = '0;
    m_mie       = '0;
    m_mip       = '0;
    m_mtimecmp  = ALL_ONES;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    assert (!rsp_valid && !rsp_redirect && !credit && !irq_pending)
      else begin
        $display("response, credit or interrupt outputs not low after reset");
        abort_run();
      end
    csr_access(`CSR_MTIMECMP, csr_pkg::RS, '0);
    csr_access(`CSR_TIME, csr_pkg::RS, '0);
    // random accesses, each followed by a read back
    repeat (30) begin
      draw_rand(r);
      draw_rand(d);
      a = pick_addr(r[2:0]);
      case (r[9:8])
        2'd0:    op = csr_pkg::RW;
        2'd1:    op = csr_pkg::RS;
        default: op = csr_pkg::RC;
      endcase
      csr_access(a, op, d);
      csr_access(a, csr_pkg::RS, '0);
    end
    csr_access(`CSR_MSTATUS, csr_pkg::RC, ALL_ONES);
    csr_access(`CSR_MSTATUS, csr_pkg::RS, '0);
    drain();
    // unknown address and the read-only time csr
    draw_rand(d);
    csr_access(12'h123, csr_pkg::RW, d);
    csr_access(12'h7FF, csr_pkg::RS, '0);
    csr_access(`CSR_TIME, csr_pkg::RS, '0);
    csr_access(`CSR_TIME, csr_pkg::RW, 64'h5);
    csr_access(`CSR_TIME, csr_pkg::RS, '0);
    drain();
    // trap entry and return, once with mie set and once clear
    draw_rand(d);
    csr_access(`CSR_MTVEC, csr_pkg::RW, d);
    csr_access(`CSR_MSTATUS, csr_pkg::RS, 64'h1 << `CSR_MIE_BIT);
    repeat (2) begin
      draw_rand(r);
      draw_rand(d);
      trap_cmd(r, d, r[63], d[4:0]);
      csr_access(`CSR_MEPC, csr_pkg::RS, '0);
      csr_access(`CSR_MCAUSE, csr_pkg::RS, '0);
      csr_access(`CSR_MTVAL, csr_pkg::RS, '0);
      csr_access(`CSR_MSTATUS, csr_pkg::RS, '0);
      mret_cmd();
      csr_access(`CSR_MSTATUS, csr_pkg::RS, '0);
      csr_access(`CSR_MSTATUS, csr_pkg::RC, 64'h1 << `CSR_MIE_BIT);
    end
    drain();
    // timer interrupt raised and then cleared
    csr_access(`CSR_MSTATUS, csr_pkg::RS, 64'h1 << `CSR_MIE_BIT);
    csr_access(`CSR_MIE, csr_pkg::RS, 64'h1 << `CSR_MTIE_BIT);
    csr_access(`CSR_MTIMECMP, csr_pkg::RW, 64'h10);
    wait_irq(1'b1);
    csr_access(`CSR_MIP, csr_pkg::RS, '0);
    csr_access(`CSR_MTIMECMP, csr_pkg::RW, ALL_ONES);
    wait_irq(1'b0);
    csr_access(`CSR_MIP, csr_pkg::RS, '0);
    drain();
    // back-to-back burst, then an idle-queue command
    repeat (10) begin
      nop_cmd();
      csr_access(`CSR_MEPC, csr_pkg::RS, '0);
    end
    drain();
    nop_cmd();
    drain();
    if ((sent != popped) || (returned != sent) || (exp_q.size() != 0)) begin
      $display("%0d commands sent, %0d responses and %0d credits seen", sent, popped, returned);
      abort_run();
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

//--- verilog.f
+incdir+common
common/csr_pkg.sv
csr_regfile/csr_regfile.sv
logic/mtimer.sv
logic/csr_cmd_fifo.sv
logic/csr_exec.sv
logic/csr_top.sv
tests/tb_clock.sv
tests/csr_tb.sv

//--- Makefile
SIM := obj_dir/csr_sim

.PHONY: compile run clean

compile:
	verilator --binary --assert --timescale 1ns/1ps --top-module csr_tb \
		-Mdir obj_dir -o csr_sim -f verilog.f

run: compile
	./$(SIM) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
